//--- Makefile
TOP := thread_ctrl_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir

//--- logic/rr_thread_sched.sv
/*
  Round-robin pointer over the running mask, one step per unstalled edge.
  With no other running thread the pointer stays put.
*/

`timescale 1ns/1ps
`default_nettype none

module rr_thread_sched (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     stall,
    input  thread_pkg::thread_mask_t run_trd,
    output thread_pkg::thread_id_t   cur_trd
);

    import thread_pkg::*;

    thread_id_t cur_q;
    thread_id_t nxt_trd;

    // Search cur+1 .. cur+7 in wrapping order
    always_comb begin
        thread_id_t idx;
        logic       found;
        nxt_trd = cur_q;
        found   = 1'b0;
        for (int k = 1; k < NUM_THREADS; k++) begin
            idx = cur_q + thread_id_t'(k);       // Wraps at NUM_THREADS
            if (!found && run_trd[idx]) begin
                nxt_trd = idx;
                found   = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cur_q <= '0;
        end else if (!stall) begin
            cur_q <= nxt_trd;
        end
    end

    assign cur_trd = cur_q;

    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> $stable(cur_trd));

endmodule

`default_nettype wire

//--- logic/thread_cmd_ctrl.sv
/*
  Command decode for create, kill, sleep and wake strobes.
  Strobes are expected one-hot; if not, create > kill > sleep > wake.
  new_trd, trd_of and invalid_op are registered, all else is combinational.
*/

`timescale 1ns/1ps
`default_nettype none

module thread_cmd_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   create,
    input  logic                   kill,
    input  logic                   sleep,
    input  logic                   wake,
    input  thread_pkg::thread_id_t act_trd,
    input  thread_pkg::thread_id_t obj_trd,
    input  logic                   pc_wr,
    input  thread_pkg::thread_id_t pc_wr_trd,
    input  thread_pkg::thread_mask_t valid_trd,
    input  thread_pkg::thread_id_t obj_par,
    output thread_pkg::state_op_e  st_op,
    output thread_pkg::thread_id_t st_trd,
    output thread_pkg::thread_id_t st_parent,
    output logic                   pc_init_en,
    output thread_pkg::thread_id_t pc_init_trd,
    output logic                   pc_wr_en,
    output thread_pkg::thread_id_t new_trd,
    output logic                   trd_of,
    output logic                   invalid_op
);

    import thread_pkg::*;

    thread_id_t free_slot;
    logic       free_found;
    logic       obj_ok;
    logic       of_nxt;
    logic       inv_nxt;

    // Lowest free slot, thread 0 is never handed out
    always_comb begin
        free_found = 1'b0;
        free_slot  = '0;
        for (int i = NUM_THREADS - 1; i >= 1; i--) begin
            if (!valid_trd[i]) begin
                free_found = 1'b1;
                free_slot  = thread_id_t'(i);
            end
        end
    end

    // Target must be live and be the actor itself or one of its children
    assign obj_ok = valid_trd[obj_trd] && ((obj_trd == act_trd) || (obj_par == act_trd));

    always_comb begin
        st_op      = ST_NONE;
        st_trd     = obj_trd;
        st_parent  = act_trd;           // Only stored on create
        pc_init_en = 1'b0;
        of_nxt     = 1'b0;
        inv_nxt    = 1'b0;
        if (create) begin
            if (free_found) begin
                st_op      = ST_CREATE;
                st_trd     = free_slot;
                pc_init_en = 1'b1;
            end else begin
                of_nxt = 1'b1;          // All slots in use
            end
        end else if (kill) begin
            if (obj_ok && (obj_trd != '0)) st_op = ST_KILL;
            else inv_nxt = 1'b1;        // Root thread cannot be killed
        end else if (sleep) begin
            if (obj_ok) st_op = ST_SLEEP;
            else inv_nxt = 1'b1;
        end else if (wake) begin
            if (obj_ok) st_op = ST_WAKE;
            else inv_nxt = 1'b1;
        end
    end

    assign pc_init_trd = free_slot;
    assign pc_wr_en    = pc_wr && valid_trd[pc_wr_trd];  // Drop writes to dead slots

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            new_trd    <= '0;
            trd_of     <= 1'b0;
            invalid_op <= 1'b0;
        end else begin
            trd_of     <= of_nxt;
            invalid_op <= inv_nxt;
            if (st_op == ST_CREATE) new_trd <= free_slot;
        end
    end

    a_one_cmd: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({create, kill, sleep, wake}));

    a_err_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(trd_of && invalid_op));

endmodule

`default_nettype wire

//--- logic/thread_ctrl_top.sv
/*
  Fetch-stage thread controller top.
  Commands are one-cycle strobes with no handshake; stall only holds the scheduler.
*/

`timescale 1ns/1ps
`default_nettype none

module thread_ctrl_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     create,
    input  logic                     kill,
    input  logic                     sleep,
    input  logic                     wake,
    input  thread_pkg::thread_id_t   act_trd,
    input  thread_pkg::thread_id_t   obj_trd,
    input  thread_pkg::pc_t          init_pc,
    input  logic                     stall,
    input  logic                     pc_wr,
    input  thread_pkg::thread_id_t   pc_wr_trd,
    input  thread_pkg::pc_t          nxt_pc,
    output thread_pkg::thread_id_t   cur_trd,
    output thread_pkg::pc_t          cur_pc,
    output thread_pkg::thread_id_t   new_trd,
    output thread_pkg::thread_mask_t valid_trd,
    output thread_pkg::thread_mask_t run_trd,
    output logic                     trd_full,
    output logic                     trd_of,
    output logic                     invalid_op,
    output thread_pkg::thread_mask_t child_trd
);

    import thread_pkg::*;

    state_op_e  st_op;
    thread_id_t st_trd;
    thread_id_t st_parent;
    thread_id_t obj_par;
    logic       pc_init_en;
    thread_id_t pc_init_trd;
    logic       pc_wr_en;

    assign trd_full = &valid_trd;

    thread_cmd_ctrl thread_cmd_ctrl_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .create      (create),
        .kill        (kill),
        .sleep       (sleep),
        .wake        (wake),
        .act_trd     (act_trd),
        .obj_trd     (obj_trd),
        .pc_wr       (pc_wr),
        .pc_wr_trd   (pc_wr_trd),
        .valid_trd   (valid_trd),
        .obj_par     (obj_par),
        .st_op       (st_op),
        .st_trd      (st_trd),
        .st_parent   (st_parent),
        .pc_init_en  (pc_init_en),
        .pc_init_trd (pc_init_trd),
        .pc_wr_en    (pc_wr_en),
        .new_trd     (new_trd),
        .trd_of      (trd_of),
        .invalid_op  (invalid_op)
    );

    thread_state_file thread_state_file_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .st_op     (st_op),
        .st_trd    (st_trd),
        .st_parent (st_parent),
        .obj_trd   (obj_trd),
        .act_trd   (act_trd),
        .valid_trd (valid_trd),
        .run_trd   (run_trd),
        .obj_par   (obj_par),
        .child_trd (child_trd)
    );

    thread_pc_file thread_pc_file_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .pc_init_en  (pc_init_en),
        .pc_init_trd (pc_init_trd),
        .init_pc     (init_pc),
        .pc_wr_en    (pc_wr_en),
        .pc_wr_trd   (pc_wr_trd),
        .nxt_pc      (nxt_pc),
        .cur_trd     (cur_trd),
        .cur_pc      (cur_pc)
    );

    rr_thread_sched rr_thread_sched_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .stall   (stall),
        .run_trd (run_trd),
        .cur_trd (cur_trd)
    );

endmodule

`default_nettype wire

//--- logic/thread_pc_file.sv
/*
  Stored PC per thread with one create write and one update write.
  A create write beats a same-cycle update to the same slot.
*/

`timescale 1ns/1ps
`default_nettype none

module thread_pc_file (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   pc_init_en,
    input  thread_pkg::thread_id_t pc_init_trd,
    input  thread_pkg::pc_t        init_pc,
    input  logic                   pc_wr_en,
    input  thread_pkg::thread_id_t pc_wr_trd,
    input  thread_pkg::pc_t        nxt_pc,
    input  thread_pkg::thread_id_t cur_trd,
    output thread_pkg::pc_t        cur_pc
);

    import thread_pkg::*;

    pc_t pc_q [NUM_THREADS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_THREADS; i++) begin
                pc_q[i] <= (i == 0) ? START_PC : '0;
            end
        end else begin
            for (int i = 0; i < NUM_THREADS; i++) begin
                if (pc_init_en && (pc_init_trd == thread_id_t'(i))) begin
                    pc_q[i] <= init_pc;              // New thread entry point
                end else if (pc_wr_en && (pc_wr_trd == thread_id_t'(i))) begin
                    pc_q[i] <= nxt_pc;
                end
            end
        end
    end

    assign cur_pc = pc_q[cur_trd];

endmodule

`default_nettype wire

//--- logic/thread_pkg.sv
/*
  Shared constants and types for the eight-thread fetch controller.
  Thread 0 is the root thread; slots 1 to 7 are handed out by create.
*/

`default_nettype none

package thread_pkg;

    localparam int NUM_THREADS = 8;             // Hardware thread slots
    localparam int TRD_W       = 3;             // Thread index width
    localparam int PC_W        = 32;            // Program counter width

    localparam logic [PC_W-1:0] START_PC = 32'h0000_1000;  // Thread 0 reset PC

    typedef logic [TRD_W-1:0]       thread_id_t;
    typedef logic [NUM_THREADS-1:0] thread_mask_t;
    typedef logic [PC_W-1:0]        pc_t;

    // Operation applied to the state file in one cycle
    typedef enum logic [2:0] {
        ST_NONE   = 3'd0,
        ST_CREATE = 3'd1,   // Set valid and running, store parent
        ST_KILL   = 3'd2,   // Clear valid and running
        ST_SLEEP  = 3'd3,   // Clear running
        ST_WAKE   = 3'd4    // Set running
    } state_op_e;

endpackage

`default_nettype wire

//--- logic/thread_state_file.sv
/*
  Valid, running and parent registers for each thread.
  Thread 0 resets as its own parent, so it shows up in its own child mask.
  Children of a killed thread keep the stale parent index.
*/

`timescale 1ns/1ps
`default_nettype none

module thread_state_file (
    input  logic                     clk,
    input  logic                     rst_n,
    input  thread_pkg::state_op_e    st_op,
    input  thread_pkg::thread_id_t   st_trd,
    input  thread_pkg::thread_id_t   st_parent,
    input  thread_pkg::thread_id_t   obj_trd,
    input  thread_pkg::thread_id_t   act_trd,
    output thread_pkg::thread_mask_t valid_trd,
    output thread_pkg::thread_mask_t run_trd,
    output thread_pkg::thread_id_t   obj_par,
    output thread_pkg::thread_mask_t child_trd
);

    import thread_pkg::*;

    thread_mask_t valid_q;
    thread_mask_t run_q;
    thread_id_t   par_q [NUM_THREADS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= thread_mask_t'(1);    // Only thread 0 alive
            run_q   <= thread_mask_t'(1);
            for (int i = 0; i < NUM_THREADS; i++) begin
                par_q[i] <= '0;
            end
        end else begin
            case (st_op)
                ST_CREATE: begin
                    valid_q[st_trd] <= 1'b1;
                    run_q[st_trd]   <= 1'b1;
                    par_q[st_trd]   <= st_parent;
                end
                ST_KILL: begin
                    valid_q[st_trd] <= 1'b0;
                    run_q[st_trd]   <= 1'b0;
                end
                ST_SLEEP: run_q[st_trd] <= 1'b0;
                ST_WAKE:  run_q[st_trd] <= 1'b1;
                default: ;
            endcase
        end
    end

    assign valid_trd = valid_q;
    assign run_trd   = run_q;
    assign obj_par   = par_q[obj_trd];       // Used for the permission check

    always_comb begin
        for (int i = 0; i < NUM_THREADS; i++) begin
            child_trd[i] = valid_q[i] && (par_q[i] == act_trd);
        end
    end

    // Every command path must keep running a subset of valid
    a_run_valid: assert property (@(posedge clk) disable iff (!rst_n)
        (run_q & ~valid_q) == '0);

endmodule

`default_nettype wire

//--- sources.f
logic/thread_pkg.sv
logic/thread_cmd_ctrl.sv
logic/thread_state_file.sv
logic/thread_pc_file.sv
logic/rr_thread_sched.sv
logic/thread_ctrl_top.sv
verif/thread_ctrl_tb.sv

//--- verif/thread_ctrl_patterns.mem
// kind act obj init_pc | exp: new_trd valid_trd run_trd child_trd trd_of invalid_op
// kind 1 create, 2 kill, 3 sleep, 4 wake; every field in hex
1 0 0 00002000  1 03 03 03 0 0
1 1 0 00003000  2 07 07 04 0 0
1 0 0 00004000  3 0F 0F 0B 0 0
1 2 0 00005000  4 1F 1F 10 0 0
1 0 0 00006000  5 3F 3F 2B 0 0
1 1 0 00007000  6 7F 7F 44 0 0
1 0 0 00008000  7 FF FF AB 0 0
// Table full, overflow and nothing written
1 0 0 00009000  7 FF FF AB 1 0
// Permissions
3 1 2 00000000  7 FF FB 44 0 0
3 3 4 00000000  7 FF FB 00 0 1
2 0 0 00000000  7 FF FB AB 0 1
4 1 2 00000000  7 FF FF 44 0 0
// Kill frees slots, create reuses the lowest
2 0 3 00000000  7 F7 F7 A3 0 0
2 2 4 00000000  7 E7 E7 00 0 0
1 5 0 0000A000  3 EF EF 08 0 0
// Sleepers for the scheduler, then a wake of a dead slot
3 0 5 00000000  3 EF CF A3 0 0
3 6 6 00000000  3 EF 8F 00 0 0
4 7 4 00000000  3 EF 8F 00 0 1

//--- verif/thread_ctrl_tb.sv
/*
  Pattern-driven testbench for the thread controller, run from the project root.
  Stall stays high while commands are applied, so cur_trd sits on thread 0 outside
  the scheduling passes, which check against a round-robin model.
*/

`timescale 1ns/1ps
`default_nettype none

module thread_ctrl_tb;

    import thread_pkg::*;

    localparam int MAX_PAT   = 32;
    localparam int PAT_WORDS = 10;          // Hex words per pattern line

    logic         clk;
    logic         rst_n;
    logic         create;
    logic         kill;
    logic         sleep;
    logic         wake;
    thread_id_t   act_trd;
    thread_id_t   obj_trd;
    pc_t          init_pc;
    logic         stall;
    logic         pc_wr;
    thread_id_t   pc_wr_trd;
    pc_t          nxt_pc;
    thread_id_t   cur_trd;
    pc_t          cur_pc;
    thread_id_t   new_trd;
    thread_mask_t valid_trd;
    thread_mask_t run_trd;
    logic         trd_full;
    logic         trd_of;
    logic         invalid_op;
    thread_mask_t child_trd;

    logic [31:0]  pat_mem [MAX_PAT*PAT_WORDS];
    pc_t          model_pc [NUM_THREADS];   // Expected PC per thread
    thread_mask_t model_run;
    thread_id_t   model_cur;
    logic         create_pc_done;           // Create PCs already walked once
    int           num_pat;
    int           err_cnt;
    int           test_err;
    int           test_cnt;
    int           fail_cnt;
    logic         watch_on = 1'b0;

    thread_ctrl_top thread_ctrl_top_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .create     (create),
        .kill       (kill),
        .sleep      (sleep),
        .wake       (wake),
        .act_trd    (act_trd),
        .obj_trd    (obj_trd),
        .init_pc    (init_pc),
        .stall      (stall),
        .pc_wr      (pc_wr),
        .pc_wr_trd  (pc_wr_trd),
        .nxt_pc     (nxt_pc),
        .cur_trd    (cur_trd),
        .cur_pc     (cur_pc),
        .new_trd    (new_trd),
        .valid_trd  (valid_trd),
        .run_trd    (run_trd),
        .trd_full   (trd_full),
        .trd_of     (trd_of),
        .invalid_op (invalid_op),
        .child_trd  (child_trd)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
            err_cnt++;
            test_err++;
        end
    endtask

    task automatic finish_test(input string name);
        test_cnt++;
        if (test_err != 0) begin
            fail_cnt++;
            $display("%s: failed with %0d mismatches", name, test_err);
        end else begin
            $display("%s: passed", name);
        end
        test_err = 0;
    endtask

    // Next running thread after cur in wrapping order or cur itself if none
    function automatic thread_id_t next_running(input thread_id_t cur, input thread_mask_t run);
        thread_id_t idx;
        int         steps;
        idx   = cur;
        steps = 0;
        do begin
            idx = idx + 3'd1;
            steps++;
        end while (!run[idx] && steps < NUM_THREADS);
        return run[idx] ? idx : cur;
    endfunction

    task automatic apply_pattern(input int n);
        int          base;
        int          gap;
        logic [31:0] kind;
        string       name;
        base = n * PAT_WORDS;
        kind = pat_mem[base];
        name = $sformatf("pattern %0d", n);
        @(posedge clk);
        create  <= (kind == 32'd1);
        kill    <= (kind == 32'd2);
        sleep   <= (kind == 32'd3);
        wake    <= (kind == 32'd4);
        act_trd <= pat_mem[base+1][TRD_W-1:0];
        obj_trd <= pat_mem[base+2][TRD_W-1:0];
        init_pc <= pat_mem[base+3];
        @(posedge clk);
        create <= 1'b0;
        kill   <= 1'b0;
        sleep  <= 1'b0;
        wake   <= 1'b0;
        @(negedge clk);                     // act_trd still held for child_trd
        check_value({name, " new_trd"}, pat_mem[base+4], 32'(new_trd));
        check_value({name, " valid_trd"}, pat_mem[base+5], 32'(valid_trd));
        check_value({name, " run_trd"}, pat_mem[base+6], 32'(run_trd));
        check_value({name, " child_trd"}, pat_mem[base+7], 32'(child_trd));
        check_value({name, " trd_of"}, pat_mem[base+8], 32'(trd_of));
        check_value({name, " invalid_op"}, pat_mem[base+9], 32'(invalid_op));
        check_value({name, " trd_full"}, 32'(&pat_mem[base+5][NUM_THREADS-1:0]),
                    32'(trd_full));
        @(negedge clk);
        check_value({name, " pulse end"}, 32'd0, 32'({trd_of, invalid_op}));
        if (kind == 32'd1 && pat_mem[base+8] == 32'd0) begin
            model_pc[pat_mem[base+4][TRD_W-1:0]] = pat_mem[base+3];
        end
        model_run = pat_mem[base+6][NUM_THREADS-1:0];
        gap = int'($urandom % 4);           // Idle cycles with stall still high
        repeat (gap) @(posedge clk);
        finish_test(name);
    endtask

    // Lets the pointer move for a number of edges and then raises stall again
    task automatic run_scheduler(input int cycles, input string name);
        @(posedge clk);
        stall <= 1'b0;
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
            if (i == cycles - 1) begin
                stall <= 1'b1;
            end
            model_cur = next_running(model_cur, model_run);
            @(negedge clk);
            check_value({name, " cur_trd"}, 32'(model_cur), 32'(cur_trd));
            check_value({name, " cur_pc"}, model_pc[model_cur], cur_pc);
        end
    endtask

    task automatic hold_stalled(input int cycles, input string name);
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
            @(negedge clk);
            check_value({name, " held cur_trd"}, 32'(model_cur), 32'(cur_trd));
        end
    endtask

    initial begin
        rst_n          = 1'b0;
        create         = 1'b0;
        kill           = 1'b0;
        sleep          = 1'b0;
        wake           = 1'b0;
        act_trd        = '0;
        obj_trd        = '0;
        init_pc        = '0;
        stall          = 1'b1;
        pc_wr          = 1'b0;
        pc_wr_trd      = '0;
        nxt_pc         = '0;
        create_pc_done = 1'b0;
        num_pat        = 0;
        err_cnt        = 0;
        test_err       = 0;
        test_cnt       = 0;
        fail_cnt       = 0;
        void'($urandom(18));
        for (int i = 0; i < MAX_PAT * PAT_WORDS; i++) begin
            pat_mem[i] = '1;                // Marks lines past the end of the file
        end
        for (int i = 0; i < NUM_THREADS; i++) begin
            model_pc[i] = (i == 0) ? START_PC : '0;
        end
        model_run = thread_mask_t'(1);
        model_cur = '0;
        $readmemh("verif/thread_ctrl_patterns.mem", pat_mem);
        while (num_pat < MAX_PAT && pat_mem[num_pat*PAT_WORDS] != '1) begin
            num_pat++;
        end
        watch_on = 1'b1;

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("reset valid_trd", 32'h01, 32'(valid_trd));
        check_value("reset run_trd", 32'h01, 32'(run_trd));
        check_value("reset cur_trd", 32'd0, 32'(cur_trd));
        check_value("reset cur_pc", START_PC, cur_pc);
        check_value("reset new_trd", 32'd0, 32'(new_trd));
        check_value("reset pulses", 32'd0, 32'({trd_of, invalid_op}));
        finish_test("reset state");

        if (num_pat == 0) begin
            $display("No pattern lines could be read from verif/thread_ctrl_patterns.mem");
            fail_cnt++;
        end else begin
            for (int n = 0; n < num_pat; n++) begin
                apply_pattern(n);
                if (!create_pc_done && (&model_run)) begin
                    // Every slot runs once, so one lap reads each create PC
                    run_scheduler(NUM_THREADS, "create pc");
                    finish_test("create pc");
                    create_pc_done = 1'b1;
                end
            end
            @(posedge clk);                 // Move thread 2 off its create PC
            pc_wr     <= 1'b1;
            pc_wr_trd <= 3'd2;
            nxt_pc    <= 32'h0000_2468;
            @(posedge clk);
            pc_wr <= 1'b0;
            model_pc[2] = 32'h0000_2468;
            run_scheduler(16, "round robin");
            finish_test("round robin");
            hold_stalled(5, "stall hold");
            run_scheduler(4, "stall hold");
            finish_test("stall hold");
        end

        $display("Tests run: %0d, failed: %0d, mismatches: %0d", test_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Watchdog sized from the pattern count
    initial begin
        int limit;
        wait (watch_on);
        limit = num_pat * 10 + 200;
        repeat (limit) @(posedge clk);
        $display("Simulation timed out after %0d cycles", limit);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire
